/* run_sim.sh */
#!/bin/sh
# Compile and run the instruction memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module reflet_inst16_tb \
    -f sim.f \
    --Mdir obj_dir \
    -o reflet_inst16_sim

sim_out=$(./obj_dir/reflet_inst16_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi

/* sim.f */
src/reflet_inst_pkg.sv
src/inst_init_seq.sv
src/inst_ram.sv
src/boot_rom.sv
src/reflet_inst16.sv
verif/reflet_inst16_checker.sv
verif/reflet_inst16_tb.sv

/* src/boot_rom.sv */
// Bootloader ROM over the top address window with registered, zero-when-idle read
`timescale 1ns/1ns

module boot_rom #(
    parameter int resetable = 1
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  logic [reflet_inst_pkg::ADDR_W-1:0]  addr,
    output logic [reflet_inst_pkg::DATA_W-1:0]  rdata
);

    import reflet_inst_pkg::*;

    localparam int IDX_W = $clog2(BOOT_LEN);

    logic [ADDR_W-1:0] offset;
    logic              in_image;
    logic [DATA_W-1:0] rom_word;

    // Offset inside the bootloader window
    assign offset = addr - BL_START_ADDR;

    // Only the first BOOT_LEN words hold code
    assign in_image = offset < ADDR_W'(BOOT_LEN);

    always_comb
    begin
        if (in_image)
        begin
            rom_word = BOOT_IMAGE[offset[IDX_W-1:0]];
        end
        else
        begin
            rom_word = '0;
        end
    end

    // Registered read giving zero on idle cycles so the top can OR outputs
    always_ff @(posedge clk)
    begin
        if (!reset && resetable != 0)
        begin
            rdata <= '0;
        end
        else if (en)
        begin
            rdata <= rom_word;
        end
        else
        begin
            rdata <= '0;
        end
    end

endmodule

/* src/inst_init_seq.sv */
// Post-reset sequencer writing the jump vector and selecting init or bus requests
`timescale 1ns/1ns

module inst_init_seq (
    input  logic                      clk,
    input  logic                      reset,
    input  reflet_inst_pkg::mem_req_t bus_req,
    output reflet_inst_pkg::mem_req_t mem_req,
    output logic                      inst_ready
);

    import reflet_inst_pkg::*;

    localparam int CNT_W = $clog2(INIT_LEN);

    logic [CNT_W-1:0]  init_cnt;
    logic [DATA_W-1:0] init_data;
    mem_req_t          init_req;

    // Count through the init words, then hold and flag ready
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            init_cnt   <= '0;
            inst_ready <= 1'b0;
        end
        else if (init_cnt == CNT_W'(INIT_LEN - 1))
        begin
            inst_ready <= 1'b1;
        end
        else
        begin
            init_cnt <= init_cnt + 1'b1;
        end
    end

    // Jump vector with the bootloader address in word 0
    always_comb
    begin
        case (init_cnt)
            CNT_W'(0):
                init_data = 16'h7D00;
            CNT_W'(1):
                init_data = 16'h0000;
            // set 0, load WR
            CNT_W'(2):
                init_data = 16'hD020;
            // jmp
            CNT_W'(3):
                init_data = 16'h001E;
            default:
                init_data = '0;
        endcase
    end

    always_comb
    begin
        init_req.addr     = ADDR_W'(init_cnt);
        init_req.data     = init_data;
        init_req.write_en = 1'b1;
    end

    // Bus only gets the memory once init is over
    assign mem_req = inst_ready ? bus_req : init_req;

endmodule

/* src/inst_ram.sv */
// Single-port instruction RAM with registered, zero-when-idle read
`timescale 1ns/1ns

module inst_ram #(
    parameter int size      = 10000,
    parameter int resetable = 1
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                en,
    input  reflet_inst_pkg::mem_req_t           req,
    output logic [reflet_inst_pkg::DATA_W-1:0]  rdata
);

    import reflet_inst_pkg::*;

    logic [DATA_W-1:0] mem [size];
    logic              in_range;
    logic              do_write;
    logic              do_read;

    // Addresses past the backed words are silently ignored
    assign in_range = 32'(req.addr) < 32'(size);
    assign do_write = en && req.write_en && in_range;
    assign do_read  = en && !req.write_en && in_range;

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[req.addr] <= req.data;
        end
    end

    // Read register cleared on any cycle that is not a valid read
    always_ff @(posedge clk)
    begin
        if (!reset && resetable != 0)
        begin
            rdata <= '0;
        end
        else if (do_read)
        begin
            rdata <= mem[req.addr];
        end
        else
        begin
            rdata <= '0;
        end
    end

endmodule

/* src/reflet_inst16.sv */
// Instruction memory top with init sequencer, RAM, bootloader ROM, window decode and read merge
`timescale 1ns/1ns

module reflet_inst16 #(
    parameter int size      = 10000,
    parameter int resetable = 1
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                enable,
    input  logic [reflet_inst_pkg::ADDR_W-1:0]  addr,
    input  logic [reflet_inst_pkg::DATA_W-1:0]  data_in,
    input  logic                                write_en,
    output logic [reflet_inst_pkg::DATA_W-1:0]  data_out,
    output logic                                inst_ready
);

    import reflet_inst_pkg::*;

    mem_req_t          bus_req;
    mem_req_t          mem_req;
    logic              in_rom_window;
    logic              ram_en;
    logic              rom_en;
    logic [DATA_W-1:0] ram_rdata;
    logic [DATA_W-1:0] rom_rdata;

    // System bus as one request
    always_comb
    begin
        bus_req.addr     = addr;
        bus_req.data     = data_in;
        bus_req.write_en = write_en;
    end

    inst_init_seq u_init_seq (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .mem_req    (mem_req),
        .inst_ready (inst_ready)
    );

    // Window decode on the selected request
    assign in_rom_window = mem_req.addr >= BL_START_ADDR;

    // RAM always enabled during init writes
    assign ram_en = !in_rom_window && (enable || !inst_ready);

    // Writes to the ROM window are dropped and read back as zero
    assign rom_en = in_rom_window && enable && inst_ready && !mem_req.write_en;

    inst_ram #(
        .size      (size),
        .resetable (resetable)
    ) u_inst_ram (
        .clk   (clk),
        .reset (reset),
        .en    (ram_en),
        .req   (mem_req),
        .rdata (ram_rdata)
    );

    boot_rom #(
        .resetable (resetable)
    ) u_boot_rom (
        .clk   (clk),
        .reset (reset),
        .en    (rom_en),
        .addr  (mem_req.addr),
        .rdata (rom_rdata)
    );

    // At most one memory returns non-zero data
    assign data_out = ram_rdata | rom_rdata;

endmodule

/* src/reflet_inst_pkg.sv */
// Address and data widths, bootloader window, memory request struct and bootloader image
package reflet_inst_pkg;

    // Word address and instruction widths
    localparam int ADDR_W = 14;
    localparam int DATA_W = 16;

    // First word of the bootloader window at the top of the address space
    localparam logic [ADDR_W-1:0] BL_START_ADDR = 14'h3E80;

    // Number of defined bootloader words
    // The rest of the window reads zero
    localparam int BOOT_LEN = 16;

    // Number of jump vector writes done after reset
    localparam int INIT_LEN = 8;

    // One request on the instruction memory bus
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic              write_en;
    } mem_req_t;

    // Bootloader program with word 0 at BL_START_ADDR
    localparam logic [DATA_W-1:0] BOOT_IMAGE [BOOT_LEN] = '{
        16'hD020,
        16'h0010,
        16'h3E01,
        16'h7C02,
        16'hA103,
        16'h2004,
        16'h5E11,
        16'h0C05,
        16'hD021,
        16'h0006,
        16'h4F12,
        16'h1E07,
        16'h9008,
        16'hD020,
        16'h7D00,
        16'h001E
    };

endpackage

/* verif/reflet_inst16_checker.sv */
// Bound assertions on inst_ready around reset and on idle read data
`timescale 1ns/1ns

module reflet_inst16_checker (
    input logic                               clk,
    input logic                               reset,
    input logic                               enable,
    input logic                               inst_ready,
    input logic [reflet_inst_pkg::DATA_W-1:0] data_out
);

    // Ready flag cleared by every reset cycle
    a_ready_low_in_reset : assert property (
        @(posedge clk)
        !reset |=> !inst_ready
    )
    else $error("inst_ready high after a reset cycle");

    // Once ready, stays ready until the next reset
    a_ready_no_fall : assert property (
        @(posedge clk) disable iff (!reset)
        inst_ready |=> inst_ready
    )
    else $error("inst_ready fell without reset");

    // Idle bus cycle gives a zero read word
    a_idle_zero : assert property (
        @(posedge clk) disable iff (!reset)
        (!enable && inst_ready) |=> (data_out == '0)
    )
    else $error("data_out not zero after an idle cycle");

endmodule

bind reflet_inst16 reflet_inst16_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .inst_ready (inst_ready),
    .data_out   (data_out)
);

/* verif/reflet_inst16_tb.sv */
// Testbench for the instruction memory with directed and random stimulus and a reference model
`timescale 1ns/1ns

module reflet_inst16_tb;

    import reflet_inst_pkg::*;

    localparam int ram_size    = 10000;
    localparam int rand_writes = 200;
    localparam int side_len    = 10;
    localparam int mix_len     = 400;
    localparam int idx_w       = $clog2(BOOT_LEN);
    localparam int test_cycles = 10 + 4 * INIT_LEN + 2 * rand_writes
                               + 3 * (BOOT_LEN + 4) + 6 * side_len + mix_len + 10;
    localparam int timeout_limit = 2 * test_cycles;

    // Jump vector as written by the init sequencer
    localparam logic [DATA_W-1:0] jump_vector [INIT_LEN] = '{
        16'h7D00, 16'h0000, 16'hD020, 16'h001E,
        16'h0000, 16'h0000, 16'h0000, 16'h0000
    };

    logic              clk;
    logic              reset;
    logic              enable;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data_in;
    logic              write_en;
    logic [DATA_W-1:0] data_out;
    logic              inst_ready;

    // Reference RAM contents and the addresses that hold known data
    logic [DATA_W-1:0] shadow [ram_size];
    bit                known [ram_size];
    logic [ADDR_W-1:0] written_q [$];

    // One-deep expected value pipeline
    logic              req_valid;
    logic [DATA_W-1:0] req_exp;
    string             req_name;
    logic              chk_valid;
    logic [DATA_W-1:0] chk_exp;
    string             chk_name;

    int errors    = 0;
    int checks    = 0;
    int cycle_cnt = 0;

    reflet_inst16 #(
        .size      (ram_size),
        .resetable (1)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .addr       (addr),
        .data_in    (data_in),
        .write_en   (write_en),
        .data_out   (data_out),
        .inst_ready (inst_ready)
    );

    always #2 clk = ~clk;

    // Expected read word for one request
    function automatic logic [DATA_W-1:0] expected_read(input logic en, input logic we,
                                                        input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] offset;
        expected_read = '0;
        if (en && !we)
        begin
            if (a >= BL_START_ADDR)
            begin
                offset = a - BL_START_ADDR;
                if (offset < ADDR_W'(BOOT_LEN))
                begin
                    expected_read = BOOT_IMAGE[offset[idx_w-1:0]];
                end
            end
            else if (int'(a) < ram_size)
            begin
                expected_read = shadow[a];
            end
        end
    endfunction

    task automatic record_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        shadow[a] = d;
        if (!known[a])
        begin
            known[a] = 1'b1;
            written_q.push_back(a);
        end
    endtask

    function automatic logic [ADDR_W-1:0] pick_written();
        int idx;
        idx = int'($urandom_range(written_q.size() - 1));
        return written_q[idx];
    endfunction

    function automatic logic [ADDR_W-1:0] random_ram_addr();
        return ADDR_W'($urandom_range(ram_size - 1));
    endfunction

    function automatic logic [ADDR_W-1:0] random_unbacked_addr();
        return ADDR_W'($urandom_range(int'(BL_START_ADDR) - 1, ram_size));
    endfunction

    function automatic logic [ADDR_W-1:0] random_window_addr();
        return BL_START_ADDR + ADDR_W'($urandom_range((1 << ADDR_W) - 1 - int'(BL_START_ADDR)));
    endfunction

    // Drive one bus request and queue its expected read word
    task automatic issue(input logic en, input logic we, input logic [ADDR_W-1:0] a,
                         input logic [DATA_W-1:0] d, input string name);
        logic [DATA_W-1:0] expected;
        @(posedge clk);
        expected = expected_read(en, we, a);
        enable    <= en;
        write_en  <= we;
        addr      <= a;
        data_in   <= d;
        req_valid <= 1'b1;
        req_exp   <= expected;
        req_name  <= name;
        if (en && we && int'(a) < ram_size)
        begin
            record_write(a, d);
        end
    endtask

    always @(posedge clk)
    begin
        chk_valid <= req_valid;
        chk_exp   <= req_exp;
        chk_name  <= req_name;
    end

    // Read data is stable around the falling edge
    always @(negedge clk)
    begin
        if (chk_valid)
        begin
            checks++;
            if (data_out !== chk_exp)
            begin
                errors++;
                $display("Mismatch in %s: expected %h, actual %h", chk_name, chk_exp, data_out);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit)
        begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial
    begin
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] side_q [$];
        int                ready_wait;
        int                kind;
        void'($urandom(32'hd321_d3bb));
        clk       = 1'b0;
        reset     = 1'b0;
        enable    = 1'b0;
        addr      = '0;
        data_in   = '0;
        write_en  = 1'b0;
        req_valid = 1'b0;
        req_exp   = '0;
        req_name  = "";
        for (int i = 0; i < INIT_LEN; i++)
        begin
            record_write(ADDR_W'(i), jump_vector[i]);
        end

        // Reset and init sequence
        repeat (10)
        begin
            @(negedge clk);
            if (inst_ready !== 1'b0)
            begin
                errors++;
                $display("inst_ready is high while reset is asserted");
            end
        end
        @(posedge clk);
        reset <= 1'b1;
        ready_wait = 0;
        @(negedge clk);
        while (inst_ready !== 1'b1 && ready_wait < 4 * INIT_LEN)
        begin
            @(negedge clk);
            ready_wait++;
        end
        if (inst_ready !== 1'b1)
        begin
            errors++;
            $display("inst_ready did not rise after the init writes");
        end
        else if (ready_wait != INIT_LEN)
        begin
            errors++;
            $display("Mismatch in init_ready_delay: expected %0d, actual %0d",
                     INIT_LEN, ready_wait);
        end
        for (int i = 0; i < INIT_LEN; i++)
        begin
            issue(1'b1, 1'b0, ADDR_W'(i), '0, "init_vector");
        end

        // Random RAM writes followed by their read back
        for (int i = 0; i < rand_writes; i++)
        begin
            a = random_ram_addr();
            side_q.push_back(a);
            issue(1'b1, 1'b1, a, DATA_W'($urandom), "ram_write");
        end
        foreach (side_q[i])
        begin
            issue(1'b1, 1'b0, side_q[i], '0, "ram_readback");
        end

        // Bootloader window before and after writes into it
        for (int i = 0; i < BOOT_LEN + 4; i++)
        begin
            issue(1'b1, 1'b0, BL_START_ADDR + ADDR_W'(i), '0, "boot_read");
        end
        for (int i = 0; i < BOOT_LEN + 4; i++)
        begin
            issue(1'b1, 1'b1, BL_START_ADDR + ADDR_W'(i), DATA_W'($urandom), "boot_write");
        end
        for (int i = 0; i < BOOT_LEN + 4; i++)
        begin
            issue(1'b1, 1'b0, BL_START_ADDR + ADDR_W'(i), '0, "boot_reread");
        end

        // Writes with enable low
        side_q.delete();
        for (int i = 0; i < side_len; i++)
        begin
            a = pick_written();
            side_q.push_back(a);
            issue(1'b0, 1'b1, a, DATA_W'($urandom), "enable_low_write");
        end
        foreach (side_q[i])
        begin
            issue(1'b1, 1'b0, side_q[i], '0, "enable_low_read");
        end

        // Addresses between the RAM and the ROM window
        for (int i = 0; i < side_len; i++)
        begin
            a = random_unbacked_addr();
            issue(1'b1, 1'b1, a, DATA_W'($urandom), "unbacked_write");
            issue(1'b1, 1'b0, a, '0, "unbacked_read");
        end
        for (int i = 0; i < side_len; i++)
        begin
            issue(1'b1, 1'b0, pick_written(), '0, "unbacked_ram_check");
        end

        // Back-to-back random mix over both windows
        for (int i = 0; i < mix_len; i++)
        begin
            kind = int'($urandom_range(5));
            case (kind)
                0, 1:
                    issue(1'b1, 1'b1, random_ram_addr(), DATA_W'($urandom), "mix_ram_write");
                2:
                    issue(1'b1, 1'b0, pick_written(), '0, "mix_ram_read");
                3:
                    issue(1'b1, 1'($urandom_range(1)), random_window_addr(),
                          DATA_W'($urandom), "mix_boot");
                4:
                    issue(1'b1, 1'($urandom_range(1)), random_unbacked_addr(),
                          DATA_W'($urandom), "mix_unbacked");
                default:
                    issue(1'b0, 1'($urandom_range(1)), random_ram_addr(),
                          DATA_W'($urandom), "mix_idle");
            endcase
        end

        issue(1'b0, 1'b0, '0, '0, "final_idle");
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
